// File: logic/lcd_pkg.sv
// ----------------------------------------------------------------------
// shared widths, register map and timing constants for the lcd block
// one clock per dot, 456 dots per line and 154 lines per frame
// mode 3 has a fixed length of 160 dots, no scroll penalty
// ----------------------------------------------------------------------
package lcd_pkg;

	// ------------------------------------------------------------------
	// data widths
	// ------------------------------------------------------------------
	typedef logic [7:0]  byte_t;
	typedef logic [7:0]  line_t;
	typedef logic [8:0]  dot_t;
	typedef logic [1:0]  shade_t;
	// palette number times four plus colour number
	typedef logic [4:0]  pal_entry_t;
	typedef logic [5:0]  pal_index_t;
	typedef logic [14:0] rgb_t;

	// stat mode, encoding matches the two low stat bits
	typedef enum logic [1:0] {
		mode_hblank   = 2'd0,
		mode_vblank   = 2'd1,
		mode_oam      = 2'd2,
		mode_transfer = 2'd3
	} lcd_mode_t;

	// ------------------------------------------------------------------
	// register addresses, low byte of 0xff40 and up
	// ------------------------------------------------------------------
	localparam byte_t REG_LCDC = 8'h40;
	localparam byte_t REG_STAT = 8'h41;
	localparam byte_t REG_SCY  = 8'h42;
	localparam byte_t REG_SCX  = 8'h43;
	localparam byte_t REG_LY   = 8'h44;
	localparam byte_t REG_LYC  = 8'h45;
	localparam byte_t REG_BGP  = 8'h47;
	localparam byte_t REG_OBP0 = 8'h48;
	localparam byte_t REG_OBP1 = 8'h49;
	localparam byte_t REG_WY   = 8'h4a;
	localparam byte_t REG_WX   = 8'h4b;
	// colour palette index and data, background then object
	localparam byte_t REG_BCPS = 8'h68;
	localparam byte_t REG_BCPD = 8'h69;
	localparam byte_t REG_OCPS = 8'h6a;
	localparam byte_t REG_OCPD = 8'h6b;

	// line and frame timing
	localparam int LINE_DOTS     = 456;
	localparam int FRAME_LINES   = 154;
	localparam int VISIBLE_LINES = 144;
	localparam int OAM_DOTS      = 80;
	localparam int VISIBLE_DOTS  = 160;
	localparam int LYC_IRQ_DOT   = 2;

	// colour palette memories
	localparam int PAL_COUNT = 2;
	localparam int PAL_BG    = 0;
	localparam int PAL_OBJ   = 1;

	localparam rgb_t WHITE_RGB = 15'h7fff;

endpackage

// File: logic/lcd_regs.sv
// ----------------------------------------------------------------------
// cpu register file of the lcd block with combinational readback
// writes land on the edge with cpu_sel and cpu_wr high
// colour palette registers read 0xff unless is_gbc is set
// dma at 0x46 and all unused addresses read 0xff
// ----------------------------------------------------------------------
module lcd_regs
	import lcd_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       is_gbc,
	input  logic       cpu_sel,
	input  logic       cpu_wr,
	input  byte_t      cpu_addr,
	input  byte_t      cpu_di,
	output byte_t      cpu_do,
	input  line_t      ly,
	input  lcd_mode_t  mode,
	input  logic       lyc_match,
	input  byte_t      pal_index_rd [PAL_COUNT],
	input  byte_t      pal_data_rd [PAL_COUNT],
	output logic [PAL_COUNT-1:0] pal_index_wr,
	output logic [PAL_COUNT-1:0] pal_data_wr,
	output byte_t      pal_wdata,
	output byte_t      lcdc,
	output logic [3:0] stat_irq_en,
	output byte_t      lyc,
	output byte_t      bgp,
	output byte_t      obp0,
	output byte_t      obp1
);

	logic  cpu_write;
	// scroll and window, readback only
	byte_t scy;
	byte_t scx;
	byte_t wy;
	byte_t wx;

	assign cpu_write = cpu_sel && cpu_wr;

	// ------------------------------------------------------------------
	// plain registers
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			// display starts switched off
			lcdc        <= 8'h00;
			stat_irq_en <= 4'h0;
			scy         <= 8'h00;
			scx         <= 8'h00;
			lyc         <= 8'h00;
			bgp         <= 8'hfc;
			obp0        <= 8'hff;
			obp1        <= 8'hff;
			wy          <= 8'h00;
			wx          <= 8'h00;
		end else if (cpu_write) begin
			case (cpu_addr)
				REG_LCDC: lcdc <= cpu_di;
				// only the four interrupt enables are writable
				REG_STAT: stat_irq_en <= cpu_di[6:3];
				REG_SCY:  scy <= cpu_di;
				REG_SCX:  scx <= cpu_di;
				REG_LYC:  lyc <= cpu_di;
				REG_BGP:  bgp <= cpu_di;
				REG_OBP0: obp0 <= cpu_di;
				REG_OBP1: obp1 <= cpu_di;
				REG_WY:   wy <= cpu_di;
				REG_WX:   wx <= cpu_di;
				default: ;
			endcase
		end
	end

	// ------------------------------------------------------------------
	// palette write strobes, the memories hold their own state
	// ------------------------------------------------------------------
	assign pal_wdata = cpu_di;

	always_comb begin
		pal_index_wr = '0;
		pal_data_wr  = '0;
		pal_index_wr[PAL_BG]  = cpu_write && (cpu_addr == REG_BCPS);
		pal_data_wr[PAL_BG]   = cpu_write && (cpu_addr == REG_BCPD);
		pal_index_wr[PAL_OBJ] = cpu_write && (cpu_addr == REG_OCPS);
		pal_data_wr[PAL_OBJ]  = cpu_write && (cpu_addr == REG_OCPD);
	end

	// readback mux
	always_comb begin
		case (cpu_addr)
			REG_LCDC: cpu_do = lcdc;
			// bit 7 always reads high
			REG_STAT: cpu_do = {1'b1, stat_irq_en, lyc_match, mode};
			REG_SCY:  cpu_do = scy;
			REG_SCX:  cpu_do = scx;
			REG_LY:   cpu_do = ly;
			REG_LYC:  cpu_do = lyc;
			REG_BGP:  cpu_do = bgp;
			REG_OBP0: cpu_do = obp0;
			REG_OBP1: cpu_do = obp1;
			REG_WY:   cpu_do = wy;
			REG_WX:   cpu_do = wx;
			REG_BCPS: cpu_do = is_gbc ? pal_index_rd[PAL_BG] : 8'hff;
			REG_BCPD: cpu_do = is_gbc ? pal_data_rd[PAL_BG] : 8'hff;
			REG_OCPS: cpu_do = is_gbc ? pal_index_rd[PAL_OBJ] : 8'hff;
			REG_OCPD: cpu_do = is_gbc ? pal_data_rd[PAL_OBJ] : 8'hff;
			default:  cpu_do = 8'hff;
		endcase
	end

endmodule

// File: logic/lcd_timing.sv
// ----------------------------------------------------------------------
// dot and line counters, stat mode and the stat interrupt pulse
// counters sit at dot 0, line 0 while reset or lcd_on is low
// irq is a one clock pulse, registered, and only fires with the lcd on
// ----------------------------------------------------------------------
module lcd_timing
	import lcd_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       lcd_on,
	// stat bits 6 to 3
	input  logic [3:0] stat_irq_en,
	input  byte_t      lyc,
	output line_t      ly,
	output lcd_mode_t  mode,
	output logic       lyc_match,
	output logic       irq
);

	dot_t dot_cnt;
	line_t line_cnt;
	logic dot_last;
	logic line_last;
	logic irq_next;

	assign dot_last  = (dot_cnt == dot_t'(LINE_DOTS - 1));
	assign line_last = (line_cnt == line_t'(FRAME_LINES - 1));

	// ------------------------------------------------------------------
	// counters
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset || !lcd_on) begin
			dot_cnt  <= '0;
			line_cnt <= '0;
		end else if (dot_last) begin
			dot_cnt <= '0;
			// new line, wrap at end of frame
			if (line_last)
				line_cnt <= '0;
			else
				line_cnt <= line_cnt + 8'd1;
		end else begin
			dot_cnt <= dot_cnt + 9'd1;
		end
	end

	assign ly        = line_cnt;
	assign lyc_match = (line_cnt == lyc);

	// mode straight from the counters
	always_comb begin
		if (!lcd_on)
			mode = mode_hblank;
		else if (line_cnt >= line_t'(VISIBLE_LINES))
			mode = mode_vblank;
		else if (dot_cnt < dot_t'(OAM_DOTS))
			mode = mode_oam;
		else if (dot_cnt < dot_t'(OAM_DOTS + VISIBLE_DOTS))
			mode = mode_transfer;
		else
			mode = mode_hblank;
	end

	// ------------------------------------------------------------------
	// interrupt sources
	// ------------------------------------------------------------------
	always_comb begin
		irq_next = 1'b0;
		// ly == lyc, checked a couple of dots into the line
		if (stat_irq_en[3] && lyc_match && (dot_cnt == dot_t'(LYC_IRQ_DOT)))
			irq_next = 1'b1;
		// oam scan start
		if (stat_irq_en[2] && (dot_cnt == '0))
			irq_next = 1'b1;
		// last dot of the last visible line, vblank follows
		if (stat_irq_en[1] && dot_last && (line_cnt == line_t'(VISIBLE_LINES - 1)))
			irq_next = 1'b1;
		// hblank start, transfer is always 160 dots
		if (stat_irq_en[0] && (dot_cnt == dot_t'(OAM_DOTS + VISIBLE_DOTS)))
			irq_next = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset)
			irq <= 1'b0;
		else
			irq <= irq_next && lcd_on;
	end

endmodule

// File: logic/palette_ram.sv
// ----------------------------------------------------------------------
// one 64 byte colour palette with index register and auto increment
// eight palettes of four colours, two bytes per colour, little endian
// color is combinational, bit 7 of the high byte is ignored
// ----------------------------------------------------------------------
module palette_ram
	import lcd_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       index_wr,
	input  logic       data_wr,
	input  byte_t      wdata,
	input  pal_entry_t entry,
	output byte_t      index_rd,
	output byte_t      data_rd,
	output rgb_t       color
);

	byte_t      mem [64];
	pal_index_t index;
	logic       auto_inc;
	byte_t      color_lo;
	byte_t      color_hi;

	// ------------------------------------------------------------------
	// index register and memory writes
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			index    <= '0;
			auto_inc <= 1'b0;
			for (int i = 0; i < 64; i++)
				mem[i] <= 8'h00;
		end else if (index_wr) begin
			index    <= wdata[5:0];
			auto_inc <= wdata[7];
		end else if (data_wr) begin
			mem[index] <= wdata;
			// wraps from 63 back to 0 by width
			if (auto_inc)
				index <= index + 6'd1;
		end
	end

	// cpu side readback
	assign index_rd = {auto_inc, 1'b0, index};
	assign data_rd  = mem[index];

	// pixel side lookup, two bytes per entry
	assign color_lo = mem[{entry, 1'b0}];
	assign color_hi = mem[{entry, 1'b1}];
	assign color    = {color_hi[6:0], color_lo};

endmodule

// File: logic/color_mapper.sv
// ----------------------------------------------------------------------
// maps a fetched pixel to rgb555, one clock of latency
// monochrome shades come out zero extended in the low two bits
// accepts a new pixel on every clock
// ----------------------------------------------------------------------
module color_mapper
	import lcd_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       is_gbc,
	// lcdc bit 0
	input  logic       bg_enable,
	input  byte_t      bgp,
	input  byte_t      obp0,
	input  byte_t      obp1,
	input  logic       pix_valid,
	input  logic       pix_obj,
	input  shade_t     pix_color,
	input  logic [2:0] pix_palette,
	output pal_entry_t pal_entry [PAL_COUNT],
	input  rgb_t       pal_color [PAL_COUNT],
	output logic       lcd_valid,
	output rgb_t       lcd_data
);

	byte_t  mono_pal;
	shade_t shade;
	rgb_t   color_next;

	// same entry to both memories, the pixel type picks the result
	always_comb begin
		for (int p = 0; p < PAL_COUNT; p++)
			pal_entry[p] = {pix_palette, pix_color};
	end

	// monochrome palette, obp1 when palette bit 0 is set
	assign mono_pal = !pix_obj ? bgp : (pix_palette[0] ? obp1 : obp0);
	assign shade    = mono_pal[{pix_color, 1'b0} +: 2];

	always_comb begin
		if (!pix_obj && !bg_enable)
			color_next = WHITE_RGB;
		else if (is_gbc)
			color_next = pix_obj ? pal_color[PAL_OBJ] : pal_color[PAL_BG];
		else
			color_next = rgb_t'(shade);
	end

	// ------------------------------------------------------------------
	// output stage
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset)
			lcd_valid <= 1'b0;
		else
			lcd_valid <= pix_valid;
	end

	always_ff @(posedge clk) begin
		lcd_data <= color_next;
	end

endmodule

// File: logic/lcd_top.sv
// ----------------------------------------------------------------------
// lcd controller top, registers, timing, colour palettes and mapper
// pixels arrive already fetched on the pix_* inputs
// single clock, no handshake anywhere
// ----------------------------------------------------------------------
module lcd_top
	import lcd_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       is_gbc,
	input  logic       cpu_sel,
	input  logic       cpu_wr,
	input  byte_t      cpu_addr,
	input  byte_t      cpu_di,
	output byte_t      cpu_do,
	input  logic       pix_valid,
	input  logic       pix_obj,
	input  shade_t     pix_color,
	input  logic [2:0] pix_palette,
	output logic       lcd_on,
	output logic       lcd_valid,
	output logic       irq,
	output rgb_t       lcd_data,
	output lcd_mode_t  mode
);

	byte_t      lcdc;
	logic [3:0] stat_irq_en;
	byte_t      lyc;
	byte_t      bgp;
	byte_t      obp0;
	byte_t      obp1;
	line_t      ly;
	logic       lyc_match;
	// palette links, one slot per memory
	logic [PAL_COUNT-1:0] pal_index_wr;
	logic [PAL_COUNT-1:0] pal_data_wr;
	byte_t      pal_wdata;
	byte_t      pal_index_rd [PAL_COUNT];
	byte_t      pal_data_rd [PAL_COUNT];
	pal_entry_t pal_entry [PAL_COUNT];
	rgb_t       pal_color [PAL_COUNT];

	// lcdc bit 7 switches the display on
	assign lcd_on = lcdc[7];

	lcd_regs i_regs (
		.clk(clk), .reset(reset), .is_gbc(is_gbc),
		.cpu_sel(cpu_sel), .cpu_wr(cpu_wr), .cpu_addr(cpu_addr),
		.cpu_di(cpu_di), .cpu_do(cpu_do),
		.ly(ly), .mode(mode), .lyc_match(lyc_match),
		.pal_index_rd(pal_index_rd), .pal_data_rd(pal_data_rd),
		.pal_index_wr(pal_index_wr), .pal_data_wr(pal_data_wr), .pal_wdata(pal_wdata),
		.lcdc(lcdc), .stat_irq_en(stat_irq_en), .lyc(lyc),
		.bgp(bgp), .obp0(obp0), .obp1(obp1)
	);

	lcd_timing i_timing (
		.clk(clk), .reset(reset), .lcd_on(lcd_on),
		.stat_irq_en(stat_irq_en), .lyc(lyc),
		.ly(ly), .mode(mode), .lyc_match(lyc_match), .irq(irq)
	);

	// background and object colour palettes
	for (genvar p = 0; p < PAL_COUNT; p++) begin : g_pal
		palette_ram i_pal (
			.clk(clk), .reset(reset),
			.index_wr(pal_index_wr[p]), .data_wr(pal_data_wr[p]), .wdata(pal_wdata),
			.entry(pal_entry[p]),
			.index_rd(pal_index_rd[p]), .data_rd(pal_data_rd[p]), .color(pal_color[p])
		);
	end

	color_mapper i_mapper (
		.clk(clk), .reset(reset), .is_gbc(is_gbc), .bg_enable(lcdc[0]),
		.bgp(bgp), .obp0(obp0), .obp1(obp1),
		.pix_valid(pix_valid), .pix_obj(pix_obj),
		.pix_color(pix_color), .pix_palette(pix_palette),
		.pal_entry(pal_entry), .pal_color(pal_color),
		.lcd_valid(lcd_valid), .lcd_data(lcd_data)
	);

endmodule

// File: tests/tb_lcd_ref.svh
// ----------------------------------------------------------------------
// reference model and check helpers for the lcd testbench
// included inside tb_lcd, uses its signals, counters and shadow copies
// positions count dots since the edge that switched the lcd on
// ----------------------------------------------------------------------
`ifndef TB_LCD_REF_SVH
`define TB_LCD_REF_SVH

// ----------------------------------------------------------------------
// timing model
// ----------------------------------------------------------------------
function automatic int line_at(int pos);
	return (pos / 456) % 154;
endfunction

function automatic lcd_mode_t mode_at(bit on, int pos);
	int dot;
	int line;
	dot = pos % 456;
	line = line_at(pos);
	if (!on)
		return mode_hblank;
	if (line >= 144)
		return mode_vblank;
	if (dot < 80)
		return mode_oam;
	// transfer is a fixed 160 dots
	if (dot < 240)
		return mode_transfer;
	return mode_hblank;
endfunction

// pulses expected over one frame with a single stat enable bit set
function automatic int irqs_per_frame(int en_bit, int lyc_val);
	int n;
	int dot;
	int line;
	n = 0;
	for (int pos = 0; pos < 456 * 154; pos++) begin
		dot = pos % 456;
		line = pos / 456;
		if ((en_bit == 6 && dot == 2 && line == lyc_val)
				|| (en_bit == 5 && dot == 0)
				|| (en_bit == 4 && dot == 455 && line == 143)
				|| (en_bit == 3 && dot == 240))
			n++;
	end
	return n;
endfunction

// colour model, mono shades or two bytes from the palette shadow
function automatic rgb_t pixel_color(bit gbc, bit bg_en, bit obj, shade_t c,
		logic [2:0] pal);
	byte_t lo;
	byte_t hi;
	byte_t mono;
	int base;
	if (!obj && !bg_en)
		return 15'h7fff;
	base = (int'(pal) * 4 + int'(c)) * 2;
	if (gbc) begin
		lo = obj ? obj_mem[base] : bg_mem[base];
		hi = obj ? obj_mem[base + 1] : bg_mem[base + 1];
		return {hi[6:0], lo};
	end
	mono = !obj ? sh_bgp : (pal[0] ? sh_obp1 : sh_obp0);
	return rgb_t'((mono >> (2 * int'(c))) & 8'h03);
endfunction

// ----------------------------------------------------------------------
// checks and bounded waits
// ----------------------------------------------------------------------
task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
	end
endtask

task automatic wait_for_mode(lcd_mode_t m, int limit, string what);
	int n;
	n = 0;
	while (mode !== m && n < limit) begin
		@(negedge clk);
		n++;
	end
	if (mode !== m) begin
		$display("Timeout: gave up waiting for %s after %0d cycles", what, limit);
		$display("Errors found");
		$finish;
	end
endtask

task automatic drain_queue(int limit);
	int n;
	n = 0;
	while (exp_q.size() != 0 && n < limit) begin
		@(negedge clk);
		n++;
	end
	if (exp_q.size() != 0) begin
		$display("Timeout: %0d expected pixels never came out", exp_q.size());
		$display("Errors found");
		$finish;
	end
endtask

`endif

// File: tests/tb_lcd.sv
// ----------------------------------------------------------------------
// testbench for lcd_top that drives the cpu bus and the pixel input
// inputs change on the falling edge and registered outputs are sampled
// one unit after the rising edge while cpu reads come one unit after the fall
// ----------------------------------------------------------------------
module tb_lcd
	import lcd_pkg::*;
();

	logic       clk;
	logic       reset;
	logic       is_gbc;
	logic       cpu_sel;
	logic       cpu_wr;
	byte_t      cpu_addr;
	byte_t      cpu_di;
	byte_t      cpu_do;
	logic       pix_valid;
	logic       pix_obj;
	shade_t     pix_color;
	logic [2:0] pix_palette;
	logic       lcd_on;
	logic       lcd_valid;
	logic       irq;
	rgb_t       lcd_data;
	lcd_mode_t  mode;

	int unsigned edges = 0;
	int unsigned on_edge;
	int errors;
	int checks;
	int tests;
	// expected colours with at most one in flight
	rgb_t exp_q[$];
	// shadow copies of what the cpu wrote
	byte_t sh_lcdc;
	byte_t sh_bgp;
	byte_t sh_obp0;
	byte_t sh_obp1;
	byte_t bg_mem[64];
	byte_t obj_mem[64];

	`include "tb_lcd_ref.svh"

	lcd_top i_dut (.*);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	always @(posedge clk) edges <= edges + 1;

	// compare process for the pixel output
	always @(posedge clk) begin
		#1;
		if (lcd_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("lcd_valid went high at %0t with no pixel sent", $time);
			end else begin
				check_value("lcd_data", 32'(lcd_data), 32'(exp_q.pop_front()));
			end
		end
	end

	// ------------------------------------------------------------------
	// bus helpers entered and left on a falling edge
	// ------------------------------------------------------------------
	task automatic write_reg(byte_t addr, byte_t data);
		cpu_sel  = 1'b1;
		cpu_wr   = 1'b1;
		cpu_addr = addr;
		cpu_di   = data;
		@(negedge clk);
		cpu_sel = 1'b0;
		cpu_wr  = 1'b0;
		if (addr == REG_LCDC)
			sh_lcdc = data;
		if (addr == REG_BGP)
			sh_bgp = data;
		if (addr == REG_OBP0)
			sh_obp0 = data;
		if (addr == REG_OBP1)
			sh_obp1 = data;
	endtask

	task automatic read_reg(byte_t addr, output byte_t data);
		cpu_sel  = 1'b1;
		cpu_addr = addr;
		#1;
		data = cpu_do;
		@(negedge clk);
		cpu_sel = 1'b0;
	endtask

	task automatic expect_reg(byte_t addr, byte_t exp, string what);
		byte_t val;
		read_reg(addr, val);
		check_value(what, 32'(val), 32'(exp));
	endtask

	task automatic end_test(string name, int first_err);
		tests++;
		$display("test %0d, %s: %0d errors", tests, name, errors - first_err);
	endtask

	// ------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------
	task automatic register_access();
		byte_t plain[8] = '{REG_SCY, REG_SCX, REG_LYC, REG_BGP,
			REG_OBP0, REG_OBP1, REG_WY, REG_WX};
		byte_t rst_val[8] = '{8'h00, 8'h00, 8'h00, 8'hfc, 8'hff, 8'hff, 8'h00, 8'h00};
		byte_t val;
		int first_err;
		first_err = errors;
		expect_reg(REG_LCDC, 8'h00, "lcdc after reset");
		// bit 7 high with ly equal to lyc in mode 0
		expect_reg(REG_STAT, 8'h84, "stat after reset");
		expect_reg(REG_LY, 8'h00, "ly after reset");
		for (int i = 0; i < 8; i++)
			expect_reg(plain[i], rst_val[i], $sformatf("reset value at %0h", plain[i]));
		// dma slot and holes in the map
		expect_reg(8'h46, 8'hff, "dma address");
		expect_reg(8'h4c, 8'hff, "unused address 4c");
		expect_reg(8'h00, 8'hff, "unused address 00");
		for (int i = 0; i < 8; i++) begin
			val = byte_t'($urandom);
			write_reg(plain[i], val);
			expect_reg(plain[i], val, $sformatf("readback at %0h", plain[i]));
		end
		// keep the display off
		val = byte_t'($urandom) & 8'h7f;
		write_reg(REG_LCDC, val);
		expect_reg(REG_LCDC, val, "lcdc readback");
		end_test("register access", first_err);
	endtask

	task automatic frame_timing();
		int pos;
		int first_err;
		first_err = errors;
		write_reg(REG_LCDC, 8'h01);
		repeat (10) begin
			expect_reg(REG_LY, 8'h00, "ly with lcd off");
			check_value("mode with lcd off", 32'(mode), 32'(mode_hblank));
			check_value("lcd_on with lcdc bit 7 clear", 32'(lcd_on), 32'(0));
		end
		write_reg(REG_LCDC, 8'h81);
		on_edge = edges;
		check_value("lcd_on with lcdc bit 7 set", 32'(lcd_on), 32'(1));
		for (int i = 0; i < 8; i++) begin
			repeat (1 + $urandom % 20000) @(negedge clk);
			pos = int'(edges - on_edge);
			check_value("mode", 32'(mode), 32'(mode_at(1'b1, pos)));
			expect_reg(REG_LY, 8'(line_at(pos)), "ly");
		end
		wait_for_mode(mode_vblank, 80000, "vblank after lcd on");
		pos = int'(edges - on_edge);
		expect_reg(REG_LY, 8'(line_at(pos)), "ly in vblank");
		write_reg(REG_LCDC, 8'h01);
		end_test("frame timing", first_err);
	endtask

	task automatic stat_interrupts();
		int count;
		int lyc_val;
		int first_err;
		first_err = errors;
		for (int b = 3; b <= 6; b++) begin
			lyc_val = (b == 6) ? 10 : 0;
			write_reg(REG_LCDC, 8'h00);
			write_reg(REG_LYC, 8'(lyc_val));
			write_reg(REG_STAT, 8'(1 << b));
			write_reg(REG_LCDC, 8'h80);
			count = 0;
			// one frame of samples starting one edge after lcd on
			repeat (456 * 154) begin
				@(posedge clk);
				#1;
				if (irq === 1'b1)
					count++;
			end
			check_value($sformatf("irq pulses for stat bit %0d", b), 32'(count),
				32'(irqs_per_frame(b, lyc_val)));
			@(negedge clk);
		end
		write_reg(REG_STAT, 8'h00);
		write_reg(REG_LCDC, 8'h01);
		end_test("stat interrupts", first_err);
	endtask

	task automatic palette_fill();
		byte_t idx_addr;
		byte_t data_addr;
		byte_t val;
		int start;
		int first_err;
		first_err = errors;
		is_gbc = 1'b1;
		for (int p = 0; p < 2; p++) begin
			idx_addr  = (p == 0) ? REG_BCPS : REG_OCPS;
			data_addr = (p == 0) ? REG_BCPD : REG_OCPD;
			start = int'($urandom % 64);
			write_reg(idx_addr, 8'h80 | 8'(start));
			for (int i = 0; i < 64; i++) begin
				val = byte_t'($urandom);
				if (p == 0)
					bg_mem[(start + i) % 64] = val;
				else
					obj_mem[(start + i) % 64] = val;
				write_reg(data_addr, val);
				// index moves on and wraps after 63
				expect_reg(idx_addr, 8'h80 | 8'((start + i + 1) % 64), "palette index");
			end
			for (int i = 0; i < 64; i++) begin
				write_reg(idx_addr, 8'(i));
				expect_reg(data_addr, (p == 0) ? bg_mem[i] : obj_mem[i], "palette data");
			end
		end
		is_gbc = 1'b0;
		for (int a = 'h68; a <= 'h6b; a++)
			expect_reg(8'(a), 8'hff, "palette register with is_gbc low");
		end_test("palette fill", first_err);
	endtask

	task automatic drive_pixels(int n);
		for (int i = 0; i < n; i++) begin
			pix_valid   = ($urandom % 4) != 0;
			pix_obj     = 1'($urandom);
			pix_color   = shade_t'($urandom);
			pix_palette = 3'($urandom);
			if (pix_valid)
				exp_q.push_back(pixel_color(is_gbc, sh_lcdc[0], pix_obj, pix_color,
					pix_palette));
			@(negedge clk);
		end
		pix_valid = 1'b0;
		drain_queue(10);
	endtask

	task automatic pixel_streams();
		int first_err;
		first_err = errors;
		write_reg(REG_LCDC, 8'h01);
		write_reg(REG_BGP, byte_t'($urandom));
		write_reg(REG_OBP0, byte_t'($urandom));
		write_reg(REG_OBP1, byte_t'($urandom));
		is_gbc = 1'b0;
		drive_pixels(300);
		is_gbc = 1'b1;
		drive_pixels(300);
		end_test("pixel colours", first_err);
		// background off while objects still map through their palettes
		first_err = errors;
		write_reg(REG_LCDC, 8'h00);
		is_gbc = 1'b0;
		drive_pixels(200);
		is_gbc = 1'b1;
		drive_pixels(200);
		end_test("background disabled", first_err);
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------
	initial begin
		void'($urandom(70));
		reset       = 1'b1;
		is_gbc      = 1'b0;
		cpu_sel     = 1'b0;
		cpu_wr      = 1'b0;
		cpu_addr    = 8'h00;
		cpu_di      = 8'h00;
		pix_valid   = 1'b0;
		pix_obj     = 1'b0;
		pix_color   = 2'd0;
		pix_palette = 3'd0;
		errors      = 0;
		checks      = 0;
		tests       = 0;
		sh_lcdc     = 8'h00;
		sh_bgp      = 8'hfc;
		sh_obp0     = 8'hff;
		sh_obp1     = 8'hff;
		// palette memories clear on reset
		foreach (bg_mem[i]) begin
			bg_mem[i]  = 8'h00;
			obj_mem[i] = 8'h00;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		register_access();
		frame_timing();
		stat_interrupts();
		palette_fill();
		pixel_streams();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+tests
logic/lcd_pkg.sv
logic/lcd_regs.sv
logic/lcd_timing.sv
logic/palette_ram.sv
logic/color_mapper.sv
logic/lcd_top.sv
tests/tb_lcd.sv

// File: run.sh
#!/usr/bin/env bash
# build the lcd testbench with verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --top-module tb_lcd -f filelist.f -o tb_lcd_sim > build.log 2>&1 \
	&& ./obj_dir/tb_lcd_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or run did not complete"; exit 1; }

cat sim.log
grep -qx "No errors" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
